// ==== hdl/regSlicePkg.sv ====
// ********************
// Shared widths, access codes and bus word views for the register slice
// Imported by every block of the data slice
// ********************

package regSlicePkg;

   // Data path and register address widths
   localparam int DataWidth    = 32;
   localparam int RegAddrWidth = 5;

   // Access size from the low two opcode bits
   localparam logic [1:0] SizeByte   = 2'd0;
   localparam logic [1:0] SizeHalf   = 2'd1;
   localparam logic [1:0] SizeWord   = 2'd2;
   // Stream put of the ra operand
   localparam logic [1:0] SizeStream = 2'd3;

   // Write-back source select
   localparam logic [1:0] WbResult = 2'd0;
   localparam logic [1:0] WbLink   = 2'd1;
   localparam logic [1:0] WbLoad   = 2'd2;
   // No register update
   localparam logic [1:0] WbKeep   = 2'd3;

   // One bus word split into lanes
   // Lane 0 is the most significant byte or halfword
   typedef union packed {
      logic [0:DataWidth/8-1][7:0]   lane;
      logic [0:DataWidth/16-1][15:0] half;
   } dataWordU;

endpackage

// ==== hdl/loadAligner.sv ====
// ********************
// Load lane selection from the data bus or stream word
// Byte select decides the lanes, the result is zero-extended
// ********************

`timescale 1ns/1ps

module loadAligner (
   input  logic [regSlicePkg::DataWidth/8-1:0] byteSel_i,
   input  regSlicePkg::dataWordU               busData_i,
   input  logic [regSlicePkg::DataWidth-1:0]   streamData_i,
   output logic [regSlicePkg::DataWidth-1:0]   loadData_o,
   output logic                                selErr_o
);

   import regSlicePkg::*;

   // Zero padding above a loaded byte or halfword
   localparam int BytePad = DataWidth - 8;
   localparam int HalfPad = DataWidth - 16;

   always_comb begin
      loadData_o = '0;
      selErr_o   = 1'b0;
      case (byteSel_i)
         // Single byte lanes
         4'b1000: begin
            loadData_o = {{BytePad{1'b0}}, busData_i.lane[0]};
         end
         4'b0100: begin
            loadData_o = {{BytePad{1'b0}}, busData_i.lane[1]};
         end
         4'b0010: begin
            loadData_o = {{BytePad{1'b0}}, busData_i.lane[2]};
         end
         4'b0001: begin
            loadData_o = {{BytePad{1'b0}}, busData_i.lane[3]};
         end
         // Upper and lower halfword
         4'b1100: begin
            loadData_o = {{HalfPad{1'b0}}, busData_i.half[0]};
         end
         4'b0011: begin
            loadData_o = {{HalfPad{1'b0}}, busData_i.half[1]};
         end
         // Full bus word
         4'b1111: begin
            loadData_o = busData_i;
         end
         // No lanes means a stream get
         4'b0000: begin
            loadData_o = streamData_i;
         end
         // Odd lane mix has no meaning
         default: begin
            loadData_o = '0;
            selErr_o   = 1'b1;
         end
      endcase
   end

endmodule

// ==== hdl/registerFile.sv ====
// ********************
// General purpose registers with two operand ports and a store port
// Write data picked by the write-back select, R0 zeroed in reset
// ********************

`timescale 1ns/1ps

module registerFile #(
   parameter int NumRegs = 32
) (
   input  logic                                 gclk,
   input  logic                                 grst,
   input  logic                                 enable_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] raAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] rbAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] rdAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] rwAddr_i,
   input  logic [1:0]                           wbSel_i,
   input  logic [regSlicePkg::DataWidth-1:0]    result_i,
   input  logic [regSlicePkg::DataWidth-1:0]    loadData_i,
   input  logic [regSlicePkg::DataWidth-3:0]    pcLink_i,
   output logic [regSlicePkg::DataWidth-1:0]    regA_o,
   output logic [regSlicePkg::DataWidth-1:0]    regB_o,
   output logic [regSlicePkg::DataWidth-1:0]    regD_o
);

   import regSlicePkg::*;

   // Index bits actually used for the array size
   localparam int IdxWidth = $clog2(NumRegs);

   // One copy per read port
   // All three always hold the same contents
   logic [DataWidth-1:0] copyA [NumRegs];
   logic [DataWidth-1:0] copyB [NumRegs];
   logic [DataWidth-1:0] copyD [NumRegs];

   logic [DataWidth-1:0] wrData;
   logic                 wrEn;
   logic [IdxWidth-1:0]  wrIdx;

   // Asynchronous reads
   assign regA_o = copyA[raAddr_i[IdxWidth-1:0]];
   assign regB_o = copyB[rbAddr_i[IdxWidth-1:0]];
   assign regD_o = copyD[rdAddr_i[IdxWidth-1:0]];

   // Write-back source
   always_comb begin
      case (wbSel_i)
         WbResult: wrData = result_i;
         // Return address is word aligned
         WbLink:   wrData = {pcLink_i, 2'b00};
         WbLoad:   wrData = loadData_i;
         // Keep never reaches the array
         default:  wrData = result_i;
      endcase
   end

   // R0 is never a write target
   assign wrEn  = enable_i && (rwAddr_i != '0) && (wbSel_i != WbKeep);
   assign wrIdx = rwAddr_i[IdxWidth-1:0];

   always_ff @(posedge gclk) begin
      if (grst) begin
         // Hardwired zero register set up here
         copyA[0] <= '0;
         copyB[0] <= '0;
         copyD[0] <= '0;
      end else if (wrEn) begin
         copyA[wrIdx] <= wrData;
         copyB[wrIdx] <= wrData;
         copyD[wrIdx] <= wrData;
      end
   end

endmodule

// ==== hdl/storeFormatter.sv ====
// ********************
// Store and stream output word with same-cycle write-back forwarding
// Replicates byte or halfword data across the bus lanes
// ********************

`timescale 1ns/1ps

module storeFormatter (
   input  logic                                 gclk,
   input  logic                                 grst,
   input  logic                                 enable_i,
   input  logic [1:0]                           sizeCode_i,
   input  logic [1:0]                           wbSel_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] raAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] rdAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0] rwAddr_i,
   input  logic [regSlicePkg::DataWidth-1:0]    regA_i,
   input  logic [regSlicePkg::DataWidth-1:0]    regD_i,
   input  logic [regSlicePkg::DataWidth-1:0]    result_i,
   input  logic [regSlicePkg::DataWidth-1:0]    loadData_i,
   output logic [regSlicePkg::DataWidth-1:0]    storeData_o
);

   import regSlicePkg::*;

   logic [DataWidth-1:0] srcA;
   logic [DataWidth-1:0] srcD;
   dataWordU             nextWord;

   // Picks the value being written this cycle over the stale register
   // Only load and result write-backs are forwarded
   function automatic logic [DataWidth-1:0] fwdValue(
      input logic [RegAddrWidth-1:0] srcAddr,
      input logic [DataWidth-1:0]    regValue
   );
      logic hit;
      hit = (srcAddr == rwAddr_i) && (rwAddr_i != '0);
      if (hit && (wbSel_i == WbLoad)) begin
         return loadData_i;
      end else if (hit && (wbSel_i == WbResult)) begin
         return result_i;
      end
      return regValue;
   endfunction

   // Store source and stream put source
   always_comb begin
      srcD = fwdValue(rdAddr_i, regD_i);
      srcA = fwdValue(raAddr_i, regA_i);
   end

   // Lane replication by access size
   always_comb begin
      case (sizeCode_i)
         SizeByte: nextWord.lane = {4{srcD[7:0]}};
         SizeHalf: nextWord.half = {2{srcD[15:0]}};
         SizeWord: nextWord      = dataWordU'(srcD);
         // Stream put sends ra unchanged
         default:  nextWord      = dataWordU'(srcA);
      endcase
   end

   // Output word held while the pipeline stalls
   always_ff @(posedge gclk) begin
      if (grst) begin
         storeData_o <= '0;
      end else if (enable_i) begin
         storeData_o <= nextWord;
      end
   end

endmodule

// ==== hdl/execDataSlice.sv ====
// ********************
// Register and memory data slice of the pipeline
// Joins load aligner, register file and store formatter
// ********************

`timescale 1ns/1ps

module execDataSlice #(
   parameter int NumRegs = 32
) (
   input  logic                                  gclk,
   input  logic                                  grst,
   input  logic                                  enable_i,
   // Opcode size bits and write-back source
   input  logic [1:0]                            sizeCode_i,
   input  logic [1:0]                            wbSel_i,
   // Register addresses from decode
   input  logic [regSlicePkg::RegAddrWidth-1:0]  raAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0]  rbAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0]  rdAddr_i,
   input  logic [regSlicePkg::RegAddrWidth-1:0]  rwAddr_i,
   // Return address without the two low bits
   input  logic [regSlicePkg::DataWidth-3:0]     pcLink_i,
   input  logic [regSlicePkg::DataWidth-1:0]     result_i,
   // Load side of the data bus and stream port
   input  logic [regSlicePkg::DataWidth/8-1:0]   byteSel_i,
   input  regSlicePkg::dataWordU                 busData_i,
   input  logic [regSlicePkg::DataWidth-1:0]     streamData_i,
   output logic [regSlicePkg::DataWidth-1:0]     regA_o,
   output logic [regSlicePkg::DataWidth-1:0]     regB_o,
   output logic [regSlicePkg::DataWidth-1:0]     busData_o,
   output logic [regSlicePkg::DataWidth-1:0]     streamData_o,
   output logic                                  selErr_o
);

   import regSlicePkg::*;

   logic [DataWidth-1:0] loadData;
   logic [DataWidth-1:0] regD;
   logic [DataWidth-1:0] storeData;

   // Input side
   loadAligner uLoadAligner (
      .byteSel_i    (byteSel_i),
      .busData_i    (busData_i),
      .streamData_i (streamData_i),
      .loadData_o   (loadData),
      .selErr_o     (selErr_o)
   );

   registerFile #(
      .NumRegs (NumRegs)
   ) uRegisterFile (
      .gclk       (gclk),
      .grst       (grst),
      .enable_i   (enable_i),
      .raAddr_i   (raAddr_i),
      .rbAddr_i   (rbAddr_i),
      .rdAddr_i   (rdAddr_i),
      .rwAddr_i   (rwAddr_i),
      .wbSel_i    (wbSel_i),
      .result_i   (result_i),
      .loadData_i (loadData),
      .pcLink_i   (pcLink_i),
      .regA_o     (regA_o),
      .regB_o     (regB_o),
      .regD_o     (regD)
   );

   // Output side
   storeFormatter uStoreFormatter (
      .gclk        (gclk),
      .grst        (grst),
      .enable_i    (enable_i),
      .sizeCode_i  (sizeCode_i),
      .wbSel_i     (wbSel_i),
      .raAddr_i    (raAddr_i),
      .rdAddr_i    (rdAddr_i),
      .rwAddr_i    (rwAddr_i),
      .regA_i      (regA_o),
      .regD_i      (regD),
      .result_i    (result_i),
      .loadData_i  (loadData),
      .storeData_o (storeData)
   );

   // Data bus and stream port share one output register
   assign busData_o    = storeData;
   assign streamData_o = storeData;

endmodule

// ==== dv/execDataSliceProperties.sv ====
// ********************
// Concurrent checks on the data slice ports
// Bound into the top level by the testbench
// ********************

`timescale 1ns/1ps

module execDataSliceProperties (
   input  logic                                 gclk,
   input  logic                                 grst,
   input  logic [regSlicePkg::RegAddrWidth-1:0] raAddr_i,
   input  logic [regSlicePkg::DataWidth/8-1:0]  byteSel_i,
   input  logic [regSlicePkg::DataWidth-1:0]    regA_i,
   input  logic [regSlicePkg::DataWidth-1:0]    busOut_i,
   input  logic [regSlicePkg::DataWidth-1:0]    streamOut_i,
   input  logic                                 selErr_i
);

   logic legalSel;

   // Single lanes, both halves, full word and stream get
   assign legalSel = byteSel_i inside {4'b1000, 4'b0100, 4'b0010, 4'b0001,
                                       4'b1100, 4'b0011, 4'b1111, 4'b0000};

   // One store register feeds both ports
   mirroredOutputs: assert property (
      @(posedge gclk) disable iff (grst) busOut_i == streamOut_i
   ) else $error("Bus and stream output words differ");

   // R0 always reads as zero
   zeroRegister: assert property (
      @(posedge gclk) disable iff (grst) (raAddr_i == '0) |-> (regA_i == '0)
   ) else $error("Register zero read back a non-zero value");

   legalSelect: assert property (
      @(posedge gclk) disable iff (grst) legalSel |-> !selErr_i
   ) else $error("Select error raised for a legal byte select");

endmodule

// ==== dv/tbExecDataSlice.sv ====
// ********************
// Table-driven testbench for the data slice with a shadow register model
// Run from the Makefile, ends with one summary line
// ********************

`timescale 1ns/1ps

module tbExecDataSlice;

   import regSlicePkg::*;

   localparam int ClkHalf       = 20;
   localparam int DriveDelay    = 2;
   localparam int ResetCycles   = 3;
   localparam int TimeoutMargin = 20;
   localparam int MaxRows       = 128;
   localparam int unsigned Seed = 32'h6752_a28d;

   // Legal byte selects, lane 0 is the top byte
   localparam logic [3:0] LoadSels [8] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001,
                                          4'b1100, 4'b0011, 4'b1111, 4'b0000};
   localparam logic [3:0] BadSels [4] = '{4'b1010, 4'b0110, 4'b1110, 4'b0101};

   logic        gclk;
   logic        grst;
   logic        enable;
   logic [1:0]  sizeCode, wbSel;
   logic [4:0]  raAddr, rbAddr, rdAddr, rwAddr;
   logic [29:0] pcLink;
   logic [3:0]  byteSel;
   logic [31:0] result, busDataIn, streamDataIn;
   logic [31:0] regA, regB, busDataOut, streamDataOut;
   logic        selErr;

   // Stimulus table, one entry per clock
   logic        rowEnable [MaxRows];
   logic [1:0]  rowSize [MaxRows], rowWb [MaxRows];
   logic [4:0]  rowRa [MaxRows], rowRb [MaxRows], rowRd [MaxRows], rowRw [MaxRows];
   logic [29:0] rowLink [MaxRows];
   logic [3:0]  rowSel [MaxRows];
   logic [31:0] rowResult [MaxRows], rowBus [MaxRows], rowStream [MaxRows];
   // Expected outputs while the row is applied
   logic [31:0] rowExpA [MaxRows], rowExpB [MaxRows], rowExpStore [MaxRows];
   logic        rowExpErr [MaxRows];

   // Reference state
   logic [31:0] shadowRegs [32];
   logic [31:0] modelStore;
   int          rowCount, errorCount, checkCount, cycleCount, cycleLimit;

   execDataSlice #(
      .NumRegs (32)
   ) dut (
      .gclk         (gclk),
      .grst         (grst),
      .enable_i     (enable),
      .sizeCode_i   (sizeCode),
      .wbSel_i      (wbSel),
      .raAddr_i     (raAddr),
      .rbAddr_i     (rbAddr),
      .rdAddr_i     (rdAddr),
      .rwAddr_i     (rwAddr),
      .pcLink_i     (pcLink),
      .result_i     (result),
      .byteSel_i    (byteSel),
      .busData_i    (busDataIn),
      .streamData_i (streamDataIn),
      .regA_o       (regA),
      .regB_o       (regB),
      .busData_o    (busDataOut),
      .streamData_o (streamDataOut),
      .selErr_o     (selErr)
   );

   bind execDataSlice execDataSliceProperties uProperties (
      .gclk        (gclk),
      .grst        (grst),
      .raAddr_i    (raAddr_i),
      .byteSel_i   (byteSel_i),
      .regA_i      (regA_o),
      .busOut_i    (busData_o),
      .streamOut_i (streamData_o),
      .selErr_i    (selErr_o)
   );

   always #ClkHalf gclk = ~gclk;

   // Cycle limit guards against a stuck run
   always @(posedge gclk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Run stopped after %0d cycles before the table was done", cycleCount);
         $display("test failed");
         $finish;
      end
   end

   task automatic compareValue(input string name, input logic [31:0] actual,
         input logic [31:0] expected);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      end
   endtask

   // Load lanes from the byte select rule
   function automatic logic [31:0] expectLoad(input logic [3:0] sel, input logic [31:0] bus,
         input logic [31:0] stream);
      logic [31:0] value;
      case (sel)
         4'b1000: value = {24'd0, bus[31:24]};
         4'b0100: value = {24'd0, bus[23:16]};
         4'b0010: value = {24'd0, bus[15:8]};
         4'b0001: value = {24'd0, bus[7:0]};
         4'b1100: value = {16'd0, bus[31:16]};
         4'b0011: value = {16'd0, bus[15:0]};
         4'b1111: value = bus;
         4'b0000: value = stream;
         default: value = 32'd0;
      endcase
      return value;
   endfunction

   function automatic logic legalSelect(input logic [3:0] sel);
      logic found;
      found = 1'b0;
      for (int k = 0; k < 8; k++) begin
         if (sel == LoadSels[k]) begin
            found = 1'b1;
         end
      end
      return found;
   endfunction

   // Same-cycle result or load write-back wins over the stored value
   function automatic logic [31:0] forwardSource(input logic [4:0] src, input logic [4:0] rw,
         input logic [1:0] wb, input logic [31:0] res, input logic [31:0] load);
      logic [31:0] value;
      value = shadowRegs[src];
      if ((src == rw) && (rw != 5'd0) && (wb == WbResult)) begin
         value = res;
      end else if ((src == rw) && (rw != 5'd0) && (wb == WbLoad)) begin
         value = load;
      end
      return value;
   endfunction

   function automatic logic [31:0] replicateStore(input logic [1:0] size,
         input logic [31:0] dValue, input logic [31:0] aValue);
      logic [31:0] word;
      case (size)
         SizeByte: word = {4{dValue[7:0]}};
         SizeHalf: word = {2{dValue[15:0]}};
         SizeWord: word = dValue;
         default:  word = aValue;
      endcase
      return word;
   endfunction

   // Appends one row with random data words and advances the model
   task automatic addRow(input logic en, input logic [1:0] size, input logic [1:0] wb,
         input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rd,
         input logic [4:0] rw, input logic [3:0] sel);
      logic [31:0] link;
      logic [31:0] load;
      logic [31:0] wrValue;
      int          n;
      n = rowCount;
      if (n >= MaxRows) begin
         errorCount++;
         $display("Stimulus table is full and a row was dropped");
         return;
      end
      link = $urandom();
      rowEnable[n] = en;
      rowSize[n]   = size;
      rowWb[n]     = wb;
      rowRa[n]     = ra;
      rowRb[n]     = rb;
      rowRd[n]     = rd;
      rowRw[n]     = rw;
      rowSel[n]    = sel;
      rowLink[n]   = link[29:0];
      rowResult[n] = $urandom();
      rowBus[n]    = $urandom();
      rowStream[n] = $urandom();
      // Reads see the state before this row's write
      rowExpA[n]     = shadowRegs[ra];
      rowExpB[n]     = shadowRegs[rb];
      rowExpStore[n] = modelStore;
      rowExpErr[n]   = !legalSelect(sel);
      load = expectLoad(sel, rowBus[n], rowStream[n]);
      if (en) begin
         modelStore = replicateStore(size, forwardSource(rd, rw, wb, rowResult[n], load),
                                     forwardSource(ra, rw, wb, rowResult[n], load));
      end
      if (en && (rw != 5'd0) && (wb != WbKeep)) begin
         case (wb)
            WbLink:  wrValue = {link[29:0], 2'b00};
            WbLoad:  wrValue = load;
            default: wrValue = rowResult[n];
         endcase
         shadowRegs[rw] = wrValue;
      end
      rowCount++;
   endtask

   task automatic buildTable();
      logic [31:0] rnd;
      logic [4:0]  prevRw;
      // Fill R1 to R31, each row reads back the previous target
      for (int r = 1; r < 32; r++) begin
         addRow(1'b1, SizeWord, WbResult, 5'(r - 1), 5'(r - 1), 5'(r - 1), 5'(r), 4'b1111);
      end
      // Link write, dropped R0 write, kept target
      addRow(1'b1, SizeWord, WbLink, 5'd31, 5'd31, 5'd4, 5'd5, 4'b1111);
      addRow(1'b1, SizeWord, WbResult, 5'd5, 5'd5, 5'd5, 5'd0, 4'b1111);
      addRow(1'b1, SizeWord, WbKeep, 5'd0, 5'd0, 5'd0, 5'd7, 4'b1111);
      addRow(1'b1, SizeWord, WbKeep, 5'd7, 5'd0, 5'd7, 5'd0, 4'b1111);
      // Loads through every legal select then the bad ones
      prevRw = 5'd7;
      for (int k = 0; k < 8; k++) begin
         addRow(1'b1, SizeWord, WbLoad, prevRw, prevRw, prevRw, 5'(10 + k), LoadSels[k]);
         prevRw = 5'(10 + k);
      end
      for (int k = 0; k < 4; k++) begin
         addRow(1'b1, SizeWord, WbLoad, prevRw, prevRw, prevRw, 5'(20 + k), BadSels[k]);
         prevRw = 5'(20 + k);
      end
      // Plain byte, half and word stores
      addRow(1'b1, SizeByte, WbKeep, prevRw, 5'd3, 5'd12, 5'd0, 4'b1111);
      addRow(1'b1, SizeHalf, WbKeep, 5'd12, 5'd17, 5'd17, 5'd0, 4'b1111);
      addRow(1'b1, SizeWord, WbKeep, 5'd17, 5'd25, 5'd25, 5'd0, 4'b1111);
      // Store source hit by the write in the same cycle
      addRow(1'b1, SizeWord, WbResult, 5'd2, 5'd9, 5'd9, 5'd9, 4'b1111);
      addRow(1'b1, SizeHalf, WbLoad, 5'd9, 5'd14, 5'd14, 5'd14, 4'b0011);
      addRow(1'b1, SizeByte, WbLink, 5'd14, 5'd6, 5'd6, 5'd6, 4'b1111);
      addRow(1'b1, SizeWord, WbResult, 5'd6, 5'd0, 5'd0, 5'd0, 4'b1111);
      // Stream put of ra with and without a hit
      addRow(1'b1, SizeStream, WbResult, 5'd8, 5'd8, 5'd1, 5'd8, 4'b1111);
      addRow(1'b1, SizeStream, WbLoad, 5'd11, 5'd8, 5'd1, 5'd11, 4'b0000);
      addRow(1'b1, SizeStream, WbKeep, 5'd11, 5'd8, 5'd1, 5'd11, 4'b1111);
      // Stalled rows must not write or move the store word
      addRow(1'b1, SizeWord, WbResult, 5'd11, 5'd11, 5'd13, 5'd15, 4'b1111);
      addRow(1'b0, SizeByte, WbResult, 5'd15, 5'd15, 5'd2, 5'd15, 4'b1111);
      addRow(1'b0, SizeStream, WbLoad, 5'd15, 5'd16, 5'd2, 5'd16, 4'b1111);
      addRow(1'b1, SizeWord, WbKeep, 5'd15, 5'd16, 5'd15, 5'd0, 4'b1111);
      // Random mix with occasional stalls
      for (int k = 0; k < 30; k++) begin
         rnd = $urandom();
         addRow(rnd[2:0] != 3'd0, rnd[5:4], rnd[7:6], rnd[12:8], rnd[17:13], rnd[22:18],
                rnd[27:23], rnd[31:28]);
      end
      // Idle row shows the last store word
      addRow(1'b1, SizeWord, WbKeep, 5'd0, 5'd0, 5'd0, 5'd0, 4'b1111);
   endtask

   initial begin
      void'($urandom(Seed));
      gclk         = 1'b0;
      grst         = 1'b1;
      enable       = 1'b0;
      sizeCode     = SizeWord;
      wbSel        = WbKeep;
      raAddr       = 5'd0;
      rbAddr       = 5'd0;
      rdAddr       = 5'd0;
      rwAddr       = 5'd0;
      pcLink       = 30'd0;
      result       = 32'd0;
      byteSel      = 4'b1111;
      busDataIn    = 32'd0;
      streamDataIn = 32'd0;
      rowCount     = 0;
      errorCount   = 0;
      checkCount   = 0;
      cycleCount   = 0;
      modelStore   = 32'd0;
      for (int r = 0; r < 32; r++) begin
         shadowRegs[r] = 32'd0;
      end
      buildTable();
      cycleLimit = rowCount + ResetCycles + TimeoutMargin;
      repeat (ResetCycles) @(posedge gclk);
      #DriveDelay;
      grst = 1'b0;
      for (int i = 0; i < rowCount; i++) begin
         enable       = rowEnable[i];
         sizeCode     = rowSize[i];
         wbSel        = rowWb[i];
         raAddr       = rowRa[i];
         rbAddr       = rowRb[i];
         rdAddr       = rowRd[i];
         rwAddr       = rowRw[i];
         pcLink       = rowLink[i];
         result       = rowResult[i];
         byteSel      = rowSel[i];
         busDataIn    = rowBus[i];
         streamDataIn = rowStream[i];
         // Mid-cycle sample, everything settled
         @(negedge gclk);
         compareValue($sformatf("regA_o row %0d", i), regA, rowExpA[i]);
         compareValue($sformatf("regB_o row %0d", i), regB, rowExpB[i]);
         compareValue($sformatf("busData_o row %0d", i), busDataOut, rowExpStore[i]);
         compareValue($sformatf("streamData_o row %0d", i), streamDataOut, rowExpStore[i]);
         compareValue($sformatf("selErr_o row %0d", i), {31'd0, selErr}, {31'd0, rowExpErr[i]});
         @(posedge gclk);
         #DriveDelay;
      end
      $display("Rows %0d, checks %0d, errors %0d", rowCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
hdl/regSlicePkg.sv
hdl/loadAligner.sv
hdl/registerFile.sv
hdl/storeFormatter.sv
hdl/execDataSlice.sv
dv/execDataSliceProperties.sv
dv/tbExecDataSlice.sv

// ==== Makefile ====
# Verilator build and run of the data slice testbench

TOP := tbExecDataSlice
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
